/* files.f */
json_pkg.sv
json_byte_if.sv
json_csr.sv
json_template.sv
field_formatter.sv
json_sequencer.sv
uart_tx.sv
json_uart_top.sv
tb_json_uart.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_json_uart -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
exit 0

/* tb_json_uart.sv */
`timescale 1ns/1ps

module tb_json_uart;

    localparam int FRAME   = 10 * json_pkg::CLKS_PER_BIT;   // Clocks per 8N1 frame
    localparam int EDGE_TO = 4 * FRAME;                      // Wait for a start bit
    localparam int ACK_TO  = 16;
    localparam int POLL_TO = 1000;                           // STATUS reads

    logic                          clk;
    logic                          rst;
    logic                          cyc;
    logic                          stb;
    logic                          we;
    logic [json_pkg::WB_ADR_W-1:0] adr;
    logic [json_pkg::WB_DAT_W-1:0] dat_w;
    logic [json_pkg::WB_DAT_W-1:0] dat_r;
    logic                          ack;
    logic                          tx;

    int         errors;
    int         checks;
    logic [7:0] rx_q[$];      // Bytes decoded from the line

    json_uart_top DUT (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .tx(tx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: byte %0d is 0x%02h '%c', expected 0x%02h '%c'",
                     $time, idx, got, got, exp, exp);
        end
    endtask

    task automatic check_status(input logic [7:0] got, input logic [7:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wb_write(input logic [json_pkg::WB_ADR_W-1:0] a, input logic [7:0] d);
        int n;
        n = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        do begin
            @(negedge clk);          // Outputs settled mid-cycle
            n++;
        end while (ack !== 1'b1 && n < ACK_TO);
        if (ack !== 1'b1) begin
            errors++;
            $display("Write to register %0d got no ack within %0d cycles", a, ACK_TO);
        end
        @(posedge clk);
        cyc <= 1'b0;                 // Drop after ack
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [json_pkg::WB_ADR_W-1:0] a, output logic [7:0] q);
        int n;
        n = 0;
        q = 'x;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        do begin
            @(negedge clk);
            n++;
        end while (ack !== 1'b1 && n < ACK_TO);
        if (ack !== 1'b1) begin
            errors++;
            $display("Read of register %0d got no ack within %0d cycles", a, ACK_TO);
        end else begin
            q = dat_r;               // Valid with ack
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // Decodes one 8N1 frame with each bit sampled near its middle
    task automatic uart_get_byte(output logic [7:0] b, output bit ok);
        int n;
        n  = 0;
        b  = '0;
        ok = 1'b0;
        do begin
            @(negedge clk);
            n++;
        end while (tx !== 1'b0 && n < EDGE_TO);
        if (tx !== 1'b0) begin
            return;                  // No start edge
        end
        repeat (json_pkg::CLKS_PER_BIT / 2) @(negedge clk);
        check_line(tx, 1'b0, "start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (json_pkg::CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;               // LSB first
        end
        repeat (json_pkg::CLKS_PER_BIT) @(negedge clk);
        check_line(tx, 1'b1, "stop bit");
        ok = 1'b1;
    endtask

    // Expected text from the message format and the clamp rules
    function automatic string expect_message(input json_pkg::fields_t f);
        int t;
        int l;
        int r;
        t = int'(f.t);
        l = int'(f.l);
        r = int'(f.r);
        if (t > json_pkg::T_MAX) t = json_pkg::T_MAX;
        if (l > json_pkg::TENTHS_MAX) l = json_pkg::TENTHS_MAX;
        if (r > json_pkg::TENTHS_MAX) r = json_pkg::TENTHS_MAX;
        return $sformatf("{\"T\":%0d,\"L\":%0d.%0d,\"R\":%0d.%0d}",
                         t, l / 10, l % 10, r / 10, r % 10);
    endfunction

    task automatic receive_message();
        logic [7:0] b;
        bit         ok;
        rx_q.delete();
        for (int i = 0; i < json_pkg::MSG_LEN; i++) begin
            uart_get_byte(b, ok);
            if (!ok) begin
                errors++;
                $display("No start bit for byte %0d within %0d cycles", i, EDGE_TO);
                break;
            end
            rx_q.push_back(b);
        end
    endtask

    task automatic compare_message(input string exp);
        checks++;
        if (rx_q.size() != json_pkg::MSG_LEN || exp.len() != json_pkg::MSG_LEN) begin
            errors++;
            $display("Received %0d bytes, expected a message of %0d bytes",
                     rx_q.size(), exp.len());
        end else begin
            for (int i = 0; i < json_pkg::MSG_LEN; i++) begin
                check_byte(rx_q[i], exp[i], i);
            end
        end
    endtask

    task automatic wait_done();
        logic [7:0] s;
        int         n;
        n = 0;
        do begin
            wb_read(json_pkg::REG_STATUS, s);
            n++;
        end while (s !== 8'h02 && n < POLL_TO);   // Done set and busy clear
        if (s !== 8'h02) begin
            errors++;
            $display("Send did not finish after %0d polls, STATUS is 0x%02h", POLL_TO, s);
        end
    endtask

    // Line must stay high with no extra frame showing up
    task automatic confirm_idle_line(input string what);
        for (int i = 0; i < 3 * FRAME; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) break;
        end
        check_line(tx, 1'b1, what);
    endtask

    task automatic write_fields(input json_pkg::fields_t f);
        wb_write(json_pkg::REG_T, {4'h0, f.t});
        wb_write(json_pkg::REG_L, {4'h0, f.l});
        wb_write(json_pkg::REG_R, {4'h0, f.r});
    endtask

    task automatic start_and_receive();
        fork
            receive_message();
            wb_write(json_pkg::REG_CTRL, 8'h01);
        join
    endtask

    task automatic send_message(input json_pkg::fields_t f);
        write_fields(f);
        start_and_receive();
        wait_done();
    endtask

    task automatic reset_state();
        logic [7:0] s;
        confirm_idle_line("line after reset");
        wb_read(json_pkg::REG_STATUS, s);
        check_status(s, 8'h00, "STATUS after reset");
    endtask

    task automatic basic_send();
        logic [7:0] s;
        send_message('{4'd1, 4'd5, 4'd5});
        compare_message("{\"T\":1,\"L\":0.5,\"R\":0.5}");
        wb_read(json_pkg::REG_STATUS, s);
        check_status(s, 8'h02, "STATUS after send");
    endtask

    task automatic saturation_send();
        send_message('{4'd15, 4'd12, 4'd10});   // All above or at the limit
        compare_message("{\"T\":9,\"L\":1.0,\"R\":1.0}");
        send_message('{4'd9, 4'd10, 4'd11});    // L exactly at the limit
        compare_message("{\"T\":9,\"L\":1.0,\"R\":1.0}");
    endtask

    task automatic start_while_busy();
        json_pkg::fields_t f;
        logic [7:0]        s;
        f = '{4'd3, 4'd7, 4'd2};
        write_fields(f);
        fork
            receive_message();
            begin
                wb_write(json_pkg::REG_CTRL, 8'h01);
                wb_read(json_pkg::REG_STATUS, s);
                check_status(s, 8'h01, "STATUS during send");
                wb_write(json_pkg::REG_CTRL, 8'h01);      // Dropped while busy
                wb_read(json_pkg::REG_STATUS, s);
                check_status(s, 8'h01, "STATUS after start while busy");
            end
        join
        compare_message(expect_message(f));
        wait_done();
        confirm_idle_line("line after message");
    endtask

    task automatic write_during_send();
        json_pkg::fields_t f_old;
        json_pkg::fields_t f_new;
        f_old = '{4'd2, 4'd3, 4'd4};
        f_new = '{4'd7, 4'd8, 4'd9};
        write_fields(f_old);
        fork
            receive_message();
            begin
                wb_write(json_pkg::REG_CTRL, 8'h01);
                write_fields(f_new);                      // Lands mid-message
            end
        join
        compare_message(expect_message(f_old));
        wait_done();
        start_and_receive();
        wait_done();
        compare_message(expect_message(f_new));
    endtask

    task automatic random_sends();
        json_pkg::fields_t f;
        repeat (20) begin
            f.t = 4'($urandom);     // Full 4-bit range so the clamp gets hit
            f.l = 4'($urandom);
            f.r = 4'($urandom);
            send_message(f);
            compare_message(expect_message(f));
        end
    endtask

    initial begin
        int unsigned seed_ret;
        errors   = 0;
        checks   = 0;
        rst      = 1'b1;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        seed_ret = $urandom(32'h1b32_31f8);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        basic_send();
        saturation_send();
        start_while_busy();
        write_during_send();
        random_sends();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* json_uart_top.sv */
`timescale 1ns/1ps

module json_uart_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [json_pkg::WB_ADR_W-1:0] adr,
    input  logic [json_pkg::WB_DAT_W-1:0] dat_w,
    output logic [json_pkg::WB_DAT_W-1:0] dat_r,
    output logic                          ack,
    output logic                          tx
);

    json_pkg::fields_t     fields;       // Host registers
    json_pkg::fields_t     fmt_fields;   // Snapshot used while sending
    json_pkg::tmpl_entry_t entry;
    json_pkg::field_id_e   fmt_fld;
    logic [1:0]            fmt_pos;
    logic [7:0]            fmt_ch;
    logic [4:0]            tmpl_addr;
    logic                  start_pulse;
    logic                  busy;
    logic                  done_pulse;

    json_byte_if byte_if ();

    json_csr u_csr (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .fields(fields),
        .start_pulse(start_pulse), .busy(busy), .done_pulse(done_pulse)
    );

    json_template u_template (.addr(tmpl_addr), .entry(entry));

    field_formatter u_fmt (.fld(fmt_fld), .pos(fmt_pos), .fields(fmt_fields), .ch(fmt_ch));

    json_sequencer u_seq (
        .clk(clk), .rst(rst), .fields(fields), .start_pulse(start_pulse),
        .busy(busy), .done_pulse(done_pulse), .tmpl_addr(tmpl_addr), .entry(entry),
        .fmt_fld(fmt_fld), .fmt_pos(fmt_pos), .fmt_fields(fmt_fields), .fmt_ch(fmt_ch),
        .out(byte_if.src)
    );

    uart_tx u_uart (.clk(clk), .rst(rst), .in(byte_if.snk), .tx(tx));

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic     clk,
    input  logic     rst,
    json_byte_if.snk in,
    output logic     tx
);

    json_pkg::tx_state_e               state;
    logic [json_pkg::BIT_CNT_W-1:0]    cnt;       // Clocks within a bit
    logic [2:0]                        bit_idx;   // Data bit number
    logic [7:0]                        shreg;     // LSB goes out first
    logic                              bit_end;

    assign in.ready = (state == json_pkg::TX_IDLE);
    assign bit_end  = (cnt == json_pkg::BIT_CNT_END);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= json_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;                 // Idle line
        end else begin
            case (state)
                json_pkg::TX_IDLE: begin
                    if (in.valid) begin
                        tx    <= 1'b0;       // Start bit
                        cnt   <= '0;
                        state <= json_pkg::TX_START;
                    end
                end
                json_pkg::TX_START: begin
                    cnt <= cnt + 1'b1;
                    if (bit_end) begin
                        tx      <= shreg[0];
                        bit_idx <= '0;
                        state   <= json_pkg::TX_DATA;
                    end
                end
                json_pkg::TX_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;   // Stop bit
                            state <= json_pkg::TX_STOP;
                        end else begin
                            tx      <= shreg[1];
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                default: begin               // TX_STOP
                    cnt <= cnt + 1'b1;
                    if (bit_end) begin
                        state <= json_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift register is payload only
    always_ff @(posedge clk) begin
        if (state == json_pkg::TX_IDLE && in.valid) begin
            shreg <= in.data;
        end else if (state == json_pkg::TX_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    // Line rests high whenever a new byte can be taken
    assert property (@(posedge clk) disable iff (rst) in.ready |-> tx);

endmodule

/* json_sequencer.sv */
`timescale 1ns/1ps

module json_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  json_pkg::fields_t     fields,
    input  logic                  start_pulse,
    output logic                  busy,
    output logic                  done_pulse,
    output logic [4:0]            tmpl_addr,
    input  json_pkg::tmpl_entry_t entry,
    output json_pkg::field_id_e   fmt_fld,
    output logic [1:0]            fmt_pos,
    output json_pkg::fields_t     fmt_fields,
    input  logic [7:0]            fmt_ch,
    json_byte_if.src              out
);

    logic [4:0]        idx;        // Template position
    logic              valid_q;
    logic              is_last;
    logic              xfer;
    json_pkg::fields_t fields_q;   // Snapshot for the whole message

    assign xfer    = out.valid && out.ready;
    assign is_last = (idx == 5'(json_pkg::MSG_LEN - 1));

    // Template and formatter both look at the current index
    assign tmpl_addr  = idx;
    assign fmt_fld    = entry.fld;
    assign fmt_pos    = entry.pos;
    assign fmt_fields = fields_q;

    // Literal or digit
    assign out.data  = (entry.kind == json_pkg::ENT_LIT) ? entry.ch : fmt_ch;
    assign out.valid = valid_q;
    assign out.last  = is_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx        <= '0;
            valid_q    <= 1'b0;
            busy       <= 1'b0;
            done_pulse <= 1'b0;
        end else begin
            done_pulse <= 1'b0;
            if (!busy) begin
                if (start_pulse) begin
                    busy    <= 1'b1;
                    valid_q <= 1'b1;       // First byte next cycle
                    idx     <= '0;
                end
            end else if (xfer) begin
                if (is_last) begin
                    valid_q    <= 1'b0;
                    busy       <= 1'b0;
                    done_pulse <= 1'b1;
                end else begin
                    idx <= idx + 5'd1;     // Step only on handshake
                end
            end
        end
    end

    // Latch fields at start so host writes during a send land in the next one
    always_ff @(posedge clk) begin
        if (start_pulse && !busy) begin
            fields_q <= fields;
        end
    end

    // Byte held steady under back-pressure from the UART
    assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> $stable(out.data));

endmodule

/* field_formatter.sv */
`timescale 1ns/1ps

module field_formatter (
    input  json_pkg::field_id_e fld,
    input  logic [1:0]          pos,
    input  json_pkg::fields_t   fields,
    output logic [7:0]          ch
);

    logic [3:0] raw;
    logic [3:0] limit;
    logic [3:0] sat;       // Clamped value

    always_comb begin
        case (fld)
            json_pkg::FLD_T: begin
                raw   = fields.t;
                limit = 4'(json_pkg::T_MAX);
            end
            json_pkg::FLD_L: begin
                raw   = fields.l;
                limit = 4'(json_pkg::TENTHS_MAX);
            end
            default: begin
                raw   = fields.r;
                limit = 4'(json_pkg::TENTHS_MAX);
            end
        endcase
        sat = (raw > limit) ? limit : raw;

        if (fld == json_pkg::FLD_T) begin
            ch = 8'h30 + {4'h0, sat};                                   // Single digit
        end else if (pos == 2'd0) begin
            ch = (sat == 4'(json_pkg::TENTHS_MAX)) ? 8'h31 : 8'h30;     // 1 only at 1.0
        end else begin
            ch = (sat == 4'(json_pkg::TENTHS_MAX)) ? 8'h30 : 8'h30 + {4'h0, sat};
        end
    end

endmodule

/* json_template.sv */
`timescale 1ns/1ps

module json_template (
    input  logic [4:0]            addr,
    output json_pkg::tmpl_entry_t entry
);

    function automatic json_pkg::tmpl_entry_t lit(input logic [7:0] c);
        return '{kind: json_pkg::ENT_LIT, ch: c, fld: json_pkg::FLD_T, pos: 2'd0};
    endfunction

    function automatic json_pkg::tmpl_entry_t slot(input json_pkg::field_id_e f,
                                                   input logic [1:0] p);
        return '{kind: json_pkg::ENT_SLOT, ch: 8'h30, fld: f, pos: p};
    endfunction

    // {"T":d,"L":d.d,"R":d.d}
    always_comb begin
        case (addr)
            5'd0:    entry = lit("{");
            5'd1:    entry = lit("\"");
            5'd2:    entry = lit("T");
            5'd3:    entry = lit("\"");
            5'd4:    entry = lit(":");
            5'd5:    entry = slot(json_pkg::FLD_T, 2'd0);
            5'd6:    entry = lit(",");
            5'd7:    entry = lit("\"");
            5'd8:    entry = lit("L");
            5'd9:    entry = lit("\"");
            5'd10:   entry = lit(":");
            5'd11:   entry = slot(json_pkg::FLD_L, 2'd0);   // Integer digit
            5'd12:   entry = lit(".");
            5'd13:   entry = slot(json_pkg::FLD_L, 2'd1);   // Tenths
            5'd14:   entry = lit(",");
            5'd15:   entry = lit("\"");
            5'd16:   entry = lit("R");
            5'd17:   entry = lit("\"");
            5'd18:   entry = lit(":");
            5'd19:   entry = slot(json_pkg::FLD_R, 2'd0);
            5'd20:   entry = lit(".");
            5'd21:   entry = slot(json_pkg::FLD_R, 2'd1);
            5'd22:   entry = lit("}");
            default: entry = lit(" ");   // Past the end, never sent
        endcase
    end

endmodule

/* json_csr.sv */
`timescale 1ns/1ps

module json_csr (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [json_pkg::WB_ADR_W-1:0] adr,
    input  logic [json_pkg::WB_DAT_W-1:0] dat_w,
    output logic [json_pkg::WB_DAT_W-1:0] dat_r,
    output logic                          ack,
    output json_pkg::fields_t             fields,
    output logic                          start_pulse,
    input  logic                          busy,
    input  logic                          done_pulse
);

    logic                          req;        // Cycle open, not yet acked
    logic                          start_ok;
    logic                          done_q;     // Sticky done
    logic [json_pkg::WB_DAT_W-1:0] rd_mux;

    assign req      = cyc && stb && !ack;
    assign start_ok = req && we && (adr == json_pkg::REG_CTRL) && dat_w[0] && !busy;

    // Read mux
    always_comb begin
        case (adr)
            json_pkg::REG_T:      rd_mux = {4'h0, fields.t};
            json_pkg::REG_L:      rd_mux = {4'h0, fields.l};
            json_pkg::REG_R:      rd_mux = {4'h0, fields.r};
            json_pkg::REG_STATUS: rd_mux = {6'h00, done_q | done_pulse, busy};
            default:              rd_mux = '0;   // CTRL reads zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack         <= 1'b0;
            start_pulse <= 1'b0;
            done_q      <= 1'b0;
            fields      <= '0;
        end else begin
            ack         <= req;          // One cycle after stb
            start_pulse <= start_ok;     // Lines up with ack
            if (start_ok) begin
                done_q <= 1'b0;          // New send clears done
            end else if (done_pulse) begin
                done_q <= 1'b1;
            end
            if (req && we) begin
                case (adr)
                    json_pkg::REG_T: fields.t <= dat_w[3:0];
                    json_pkg::REG_L: fields.l <= dat_w[3:0];
                    json_pkg::REG_R: fields.r <= dat_w[3:0];
                    default: ;           // CTRL goes through start_ok and STATUS is read only
                endcase
            end
        end
    end

    // Read data captured with the request and held through ack
    always_ff @(posedge clk) begin
        if (req && !we) begin
            dat_r <= rd_mux;
        end
    end

    // Master holds stb until it sees ack
    assert property (@(posedge clk) disable iff (rst) ack |-> stb);

endmodule

/* json_byte_if.sv */
`timescale 1ns/1ps

// Byte stream from the sequencer to the UART
interface json_byte_if;
    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;      // Final byte of a message

    modport src (
        output data, valid, last,
        input  ready
    );

    modport snk (
        input  data, valid, last,
        output ready
    );

endinterface

/* json_pkg.sv */
package json_pkg;

    // Message and line timing
    localparam int MSG_LEN      = 23;                // {"T":d,"L":d.d,"R":d.d}
    localparam int CLKS_PER_BIT = 8;                 // Kept small for simulation
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam logic [BIT_CNT_W-1:0] BIT_CNT_END = BIT_CNT_W'(CLKS_PER_BIT - 1);

    // Field limits
    localparam int TENTHS_MAX = 10;                  // Prints as 1.0
    localparam int T_MAX      = 9;

    // Wishbone geometry
    localparam int WB_ADR_W = 3;
    localparam int WB_DAT_W = 8;

    // Register map
    localparam logic [WB_ADR_W-1:0] REG_T      = 3'd0;
    localparam logic [WB_ADR_W-1:0] REG_L      = 3'd1;
    localparam logic [WB_ADR_W-1:0] REG_R      = 3'd2;
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 3'd3;   // Bit 0 starts a send
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 3'd4;   // Bit 0 busy, bit 1 done

    typedef enum logic [1:0] {FLD_T, FLD_L, FLD_R} field_id_e;

    typedef enum logic {ENT_LIT, ENT_SLOT} entry_kind_e;

    typedef struct packed {
        entry_kind_e kind;
        logic [7:0]  ch;       // Literal character, unused for slots
        field_id_e   fld;
        logic [1:0]  pos;      // 0 integer digit, 1 tenths digit
    } tmpl_entry_t;

    typedef struct packed {
        logic [3:0] t;
        logic [3:0] l;         // Tenths
        logic [3:0] r;         // Tenths
    } fields_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage
